// ==== common/spu_pkg.sv ====
package spu_pkg;

  typedef enum logic [3:0] {
    op_nop  = 4'd0,
    op_lnop = 4'd1,
    op_add  = 4'd2,
    op_ai   = 4'd3,
    op_mul  = 4'd4,
    op_shl  = 4'd5,
    op_load = 4'd6,
    op_br   = 4'd7
  } op_e;

  typedef enum logic {
    pipe_even = 1'b0,
    pipe_odd  = 1'b1
  } pipe_e;

  localparam int op_msb  = 31;
  localparam int op_lsb  = 28;
  localparam int rt_msb  = 27;
  localparam int rt_lsb  = 21;
  localparam int ra_msb  = 20;
  localparam int ra_lsb  = 14;
  localparam int rb_msb  = 13;
  localparam int rb_lsb  = 7;
  localparam int imm_msb = 13;
  localparam int imm_lsb = 4;

  typedef logic [6:0] reg_addr_t;
  typedef logic [2:0] lat_t;
  typedef logic [imm_msb-imm_lsb:0] imm_t;

  localparam lat_t lat_add  = 3'd2; // Also used by ai
  localparam lat_t lat_shl  = 3'd4;
  localparam lat_t lat_load = 3'd6;
  localparam lat_t lat_mul  = 3'd7;
  localparam lat_t lat_br   = 3'd1;
  localparam lat_t lat_nop  = 3'd0;

  // Ages 1 to 6 cover the longest latency of 7
  localparam int track_depth = 6;

  function automatic op_e to_op(logic [3:0] code);
    if (code <= 4'd7) return op_e'(code); // Codes 8 to 15 are not defined
    return op_nop;
  endfunction

  function automatic pipe_e pipe_of(op_e op);
    if (op inside {op_lnop, op_shl, op_load, op_br}) return pipe_odd;
    return pipe_even;
  endfunction

  function automatic lat_t lat_of(op_e op);
    case (op)
      op_add, op_ai: return lat_add;
      op_shl:        return lat_shl;
      op_load:       return lat_load;
      op_mul:        return lat_mul;
      op_br:         return lat_br;
      default:       return lat_nop;
    endcase
  endfunction

  function automatic logic writes_rt(op_e op);
    return !(op inside {op_br, op_nop, op_lnop});
  endfunction

  function automatic logic reads_ra(op_e op);
    return op inside {op_add, op_ai, op_mul, op_shl, op_load, op_br};
  endfunction

  function automatic logic reads_rb(op_e op);
    return op inside {op_add, op_mul, op_shl};
  endfunction

endpackage

// ==== common/slot_if.sv ====
interface slot_if;
  spu_pkg::op_e      op;
  spu_pkg::reg_addr_t rt;
  spu_pkg::reg_addr_t ra;
  spu_pkg::reg_addr_t rb;
  spu_pkg::imm_t     imm;
  logic              reg_wr;
  logic              reads_ra;
  logic              reads_rb;
  spu_pkg::lat_t     latency;

  modport src (
    output op, rt, ra, rb, imm, reg_wr, reads_ra, reads_rb, latency
  );

  modport dst (
    input op, rt, ra, rb, imm, reg_wr, reads_ra, reads_rb, latency
  );
endinterface

// ==== decode/pair_decoder.sv ====
module pair_decoder (
  input  logic [31:0] instr_in1,
  input  logic [31:0] instr_in2,
  slot_if.src         even_slot,
  slot_if.src         odd_slot
);

  spu_pkg::op_e op1;
  spu_pkg::op_e op2;
  spu_pkg::op_e even_op;
  spu_pkg::op_e odd_op;
  logic         swap;
  logic [31:0]  even_instr;
  logic [31:0]  odd_instr;

  assign op1 = spu_pkg::to_op(instr_in1[spu_pkg::op_msb:spu_pkg::op_lsb]);
  assign op2 = spu_pkg::to_op(instr_in2[spu_pkg::op_msb:spu_pkg::op_lsb]);

  // Fetch always pairs one op of each class, so only the first needs a look
  assign swap = spu_pkg::pipe_of(op1) == spu_pkg::pipe_odd;

  assign even_instr = swap ? instr_in2 : instr_in1;
  assign odd_instr  = swap ? instr_in1 : instr_in2;
  assign even_op    = swap ? op2 : op1;
  assign odd_op     = swap ? op1 : op2;

  assign even_slot.op       = even_op;
  assign even_slot.rt       = even_instr[spu_pkg::rt_msb:spu_pkg::rt_lsb];
  assign even_slot.ra       = even_instr[spu_pkg::ra_msb:spu_pkg::ra_lsb];
  assign even_slot.rb       = even_instr[spu_pkg::rb_msb:spu_pkg::rb_lsb];
  assign even_slot.imm      = even_instr[spu_pkg::imm_msb:spu_pkg::imm_lsb];
  assign even_slot.reg_wr   = spu_pkg::writes_rt(even_op);
  assign even_slot.reads_ra = spu_pkg::reads_ra(even_op);
  assign even_slot.reads_rb = spu_pkg::reads_rb(even_op);
  assign even_slot.latency  = spu_pkg::lat_of(even_op);

  assign odd_slot.op        = odd_op;
  assign odd_slot.rt        = odd_instr[spu_pkg::rt_msb:spu_pkg::rt_lsb];
  assign odd_slot.ra        = odd_instr[spu_pkg::ra_msb:spu_pkg::ra_lsb];
  assign odd_slot.rb        = odd_instr[spu_pkg::rb_msb:spu_pkg::rb_lsb];
  assign odd_slot.imm       = odd_instr[spu_pkg::imm_msb:spu_pkg::imm_lsb];
  assign odd_slot.reg_wr    = spu_pkg::writes_rt(odd_op);
  assign odd_slot.reads_ra  = spu_pkg::reads_ra(odd_op);
  assign odd_slot.reads_rb  = spu_pkg::reads_rb(odd_op);
  assign odd_slot.latency   = spu_pkg::lat_of(odd_op);

endmodule

// ==== hazard/inflight_tracker.sv ====
module inflight_tracker (
  input  logic clk,
  input  logic rst,
  input  logic kill,
  slot_if.dst  new_even,
  slot_if.dst  new_odd,
  output logic [spu_pkg::track_depth-1:0]               pend_even,
  output logic [spu_pkg::track_depth-1:0]               pend_odd,
  output spu_pkg::reg_addr_t [spu_pkg::track_depth-1:0] dst_even,
  output spu_pkg::reg_addr_t [spu_pkg::track_depth-1:0] dst_odd
);

  // Index 0 is the even pipe and index 1 the odd pipe
  // Bit a of each vector holds age a+1
  logic [spu_pkg::track_depth-1:0] wr_q [2];
  spu_pkg::reg_addr_t dst_q [2][spu_pkg::track_depth];
  spu_pkg::lat_t      lat_q [2][spu_pkg::track_depth];
  logic               in_wr  [2];
  spu_pkg::reg_addr_t in_dst [2];
  spu_pkg::lat_t      in_lat [2];

  assign in_wr[0]  = new_even.reg_wr;
  assign in_wr[1]  = new_odd.reg_wr;
  assign in_dst[0] = new_even.rt;
  assign in_dst[1] = new_odd.rt;
  assign in_lat[0] = new_even.latency;
  assign in_lat[1] = new_odd.latency;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_q[0] <= '0;
      wr_q[1] <= '0;
    end else begin
      for (int p = 0; p < 2; p++) begin
        // A taken branch cancels what lands in ages 1 and 2
        wr_q[p] <= {wr_q[p][spu_pkg::track_depth-2:1], {wr_q[p][0], in_wr[p]} & {2{~kill}}};
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < 2; p++) begin
      dst_q[p][0] <= in_dst[p];
      lat_q[p][0] <= in_lat[p];
      for (int a = 1; a < spu_pkg::track_depth; a++) begin
        dst_q[p][a] <= dst_q[p][a-1];
        lat_q[p][a] <= lat_q[p][a-1];
      end
    end
  end

  always_comb begin
    for (int a = 0; a < spu_pkg::track_depth; a++) begin
      pend_even[a] = wr_q[0][a] && ((a + 1) < lat_q[0][a]); // Result not ready yet
      pend_odd[a]  = wr_q[1][a] && ((a + 1) < lat_q[1][a]);
      dst_even[a]  = dst_q[0][a];
      dst_odd[a]   = dst_q[1][a];
    end
  end

endmodule

// ==== hazard/hazard_unit.sv ====
module hazard_unit (
  slot_if.dst  even_slot,
  slot_if.dst  odd_slot,
  input  logic [spu_pkg::track_depth-1:0]               pend_even,
  input  logic [spu_pkg::track_depth-1:0]               pend_odd,
  input  spu_pkg::reg_addr_t [spu_pkg::track_depth-1:0] dst_even,
  input  spu_pkg::reg_addr_t [spu_pkg::track_depth-1:0] dst_odd,
  input  logic is_branch,
  input  logic branch_taken,
  output logic hazard,
  output logic kill
);

  spu_pkg::reg_addr_t src_addr [4];
  logic               src_used [4];

  assign src_addr[0] = even_slot.ra;
  assign src_addr[1] = even_slot.rb;
  assign src_addr[2] = odd_slot.ra;
  assign src_addr[3] = odd_slot.rb;
  assign src_used[0] = even_slot.reads_ra;
  assign src_used[1] = even_slot.reads_rb;
  assign src_used[2] = odd_slot.reads_ra;
  assign src_used[3] = odd_slot.reads_rb;

  // Four sources against six ages in each of the two pipes
  always_comb begin
    hazard = 1'b0;
    for (int s = 0; s < 4; s++) begin
      for (int a = 0; a < spu_pkg::track_depth; a++) begin
        if (src_used[s] && pend_even[a] && src_addr[s] == dst_even[a]) begin
          hazard = 1'b1;
        end
        if (src_used[s] && pend_odd[a] && src_addr[s] == dst_odd[a]) begin
          hazard = 1'b1;
        end
      end
    end
  end

  assign kill = is_branch & branch_taken; // Resolved branch flushes the younger work

endmodule

// ==== design/issue_stage.sv ====
module issue_stage (
  input  logic       clk,
  input  logic       rst,
  input  logic       hazard,
  input  logic       kill,
  input  logic [9:0] pc_in,
  slot_if.dst        dec_even,
  slot_if.dst        dec_odd,
  slot_if.src        iss_even,
  slot_if.src        iss_odd,
  output logic       stall,
  output logic       flush,
  output logic [9:0] pc_out
);

  // Cleared by a hazard or a kill so that both slots read as nops
  logic               live_q;
  spu_pkg::op_e       even_op_q, odd_op_q;
  spu_pkg::reg_addr_t even_rt_q, even_ra_q, even_rb_q;
  spu_pkg::reg_addr_t odd_rt_q, odd_ra_q, odd_rb_q;
  spu_pkg::imm_t      even_imm_q, odd_imm_q;
  logic               even_wr_q, even_rra_q, even_rrb_q;
  logic               odd_wr_q, odd_rra_q, odd_rrb_q;
  spu_pkg::lat_t      even_lat_q, odd_lat_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      live_q <= 1'b0;
      stall  <= 1'b0;
      flush  <= 1'b0;
      pc_out <= '0;
    end else begin
      live_q <= ~(kill | hazard);
      stall  <= hazard & ~kill; // Kill wins over a data hazard
      flush  <= kill;
      pc_out <= pc_in;
    end
  end

  always_ff @(posedge clk) begin
    even_op_q  <= dec_even.op;
    even_rt_q  <= dec_even.rt;
    even_ra_q  <= dec_even.ra;
    even_rb_q  <= dec_even.rb;
    even_imm_q <= dec_even.imm;
    even_wr_q  <= dec_even.reg_wr;
    even_rra_q <= dec_even.reads_ra;
    even_rrb_q <= dec_even.reads_rb;
    even_lat_q <= dec_even.latency;
    odd_op_q   <= dec_odd.op;
    odd_rt_q   <= dec_odd.rt;
    odd_ra_q   <= dec_odd.ra;
    odd_rb_q   <= dec_odd.rb;
    odd_imm_q  <= dec_odd.imm;
    odd_wr_q   <= dec_odd.reg_wr;
    odd_rra_q  <= dec_odd.reads_ra;
    odd_rrb_q  <= dec_odd.reads_rb;
    odd_lat_q  <= dec_odd.latency;
  end

  assign iss_even.op       = live_q ? even_op_q : spu_pkg::op_nop;
  assign iss_even.rt       = live_q ? even_rt_q : '0;
  assign iss_even.ra       = live_q ? even_ra_q : '0;
  assign iss_even.rb       = live_q ? even_rb_q : '0;
  assign iss_even.imm      = live_q ? even_imm_q : '0;
  assign iss_even.reg_wr   = live_q & even_wr_q;
  assign iss_even.reads_ra = live_q & even_rra_q;
  assign iss_even.reads_rb = live_q & even_rrb_q;
  assign iss_even.latency  = live_q ? even_lat_q : '0;

  assign iss_odd.op        = live_q ? odd_op_q : spu_pkg::op_lnop;
  assign iss_odd.rt        = live_q ? odd_rt_q : '0;
  assign iss_odd.ra        = live_q ? odd_ra_q : '0;
  assign iss_odd.rb        = live_q ? odd_rb_q : '0;
  assign iss_odd.imm       = live_q ? odd_imm_q : '0;
  assign iss_odd.reg_wr    = live_q & odd_wr_q;
  assign iss_odd.reads_ra  = live_q & odd_rra_q;
  assign iss_odd.reads_rb  = live_q & odd_rrb_q;
  assign iss_odd.latency   = live_q ? odd_lat_q : '0;

endmodule

// ==== design/decode_issue_top.sv ====
module decode_issue_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               is_branch,
  input  logic               branch_taken,
  input  logic [9:0]         pc_in,
  input  logic [31:0]        instr_in1,
  input  logic [31:0]        instr_in2,
  output spu_pkg::op_e       op_even,
  output spu_pkg::reg_addr_t rt_even,
  output spu_pkg::reg_addr_t ra_even,
  output spu_pkg::reg_addr_t rb_even,
  output spu_pkg::imm_t      imm_even,
  output logic               reg_wr_even,
  output spu_pkg::lat_t      latency_even,
  output spu_pkg::op_e       op_odd,
  output spu_pkg::reg_addr_t rt_odd,
  output spu_pkg::reg_addr_t ra_odd,
  output spu_pkg::reg_addr_t rb_odd,
  output spu_pkg::imm_t      imm_odd,
  output logic               reg_wr_odd,
  output spu_pkg::lat_t      latency_odd,
  output logic               stall,
  output logic               flush,
  output logic [9:0]         pc_out
);

  logic hazard;
  logic kill;
  logic [spu_pkg::track_depth-1:0]               pend_even;
  logic [spu_pkg::track_depth-1:0]               pend_odd;
  spu_pkg::reg_addr_t [spu_pkg::track_depth-1:0] dst_even;
  spu_pkg::reg_addr_t [spu_pkg::track_depth-1:0] dst_odd;

  slot_if dec_even ();
  slot_if dec_odd ();
  slot_if iss_even ();
  slot_if iss_odd ();

  pair_decoder u_decoder (
    .instr_in1 (instr_in1),
    .instr_in2 (instr_in2),
    .even_slot (dec_even),
    .odd_slot  (dec_odd)
  );

  hazard_unit u_hazard (
    .even_slot    (dec_even),
    .odd_slot     (dec_odd),
    .pend_even    (pend_even),
    .pend_odd     (pend_odd),
    .dst_even     (dst_even),
    .dst_odd      (dst_odd),
    .is_branch    (is_branch),
    .branch_taken (branch_taken),
    .hazard       (hazard),
    .kill         (kill)
  );

  inflight_tracker u_tracker (
    .clk       (clk),
    .rst       (rst),
    .kill      (kill),
    .new_even  (iss_even),
    .new_odd   (iss_odd),
    .pend_even (pend_even),
    .pend_odd  (pend_odd),
    .dst_even  (dst_even),
    .dst_odd   (dst_odd)
  );

  issue_stage u_issue (
    .clk      (clk),
    .rst      (rst),
    .hazard   (hazard),
    .kill     (kill),
    .pc_in    (pc_in),
    .dec_even (dec_even),
    .dec_odd  (dec_odd),
    .iss_even (iss_even),
    .iss_odd  (iss_odd),
    .stall    (stall),
    .flush    (flush),
    .pc_out   (pc_out)
  );

  assign op_even      = iss_even.op;
  assign rt_even      = iss_even.rt;
  assign ra_even      = iss_even.ra;
  assign rb_even      = iss_even.rb;
  assign imm_even     = iss_even.imm;
  assign reg_wr_even  = iss_even.reg_wr;
  assign latency_even = iss_even.latency;
  assign op_odd       = iss_odd.op;
  assign rt_odd       = iss_odd.rt;
  assign ra_odd       = iss_odd.ra;
  assign rb_odd       = iss_odd.rb;
  assign imm_odd      = iss_odd.imm;
  assign reg_wr_odd   = iss_odd.reg_wr;
  assign latency_odd  = iss_odd.latency;

endmodule

// ==== test/tb_decode_issue.sv ====
module tb_decode_issue;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_period = 40;
  localparam int n_cycles = 3000;

  logic        clk;
  logic        rst;
  logic        is_branch;
  logic        branch_taken;
  logic [9:0]  pc_in;
  logic [31:0] instr_in1;
  logic [31:0] instr_in2;
  logic [3:0]  op_even, op_odd;
  logic [6:0]  rt_even, ra_even, rb_even;
  logic [6:0]  rt_odd, ra_odd, rb_odd;
  logic [9:0]  imm_even, imm_odd;
  logic        reg_wr_even, reg_wr_odd;
  logic [2:0]  latency_even, latency_odd;
  logic        stall, flush;
  logic [9:0]  pc_out;

  logic [31:0] seed = 32'hf05d_95cf;
  int          cycle_count = 0;
  bit          finished = 1'b0;
  int          n_stall = 0;
  int          n_expiry = 0;
  int          n_flush_hz = 0;

  // Expected outputs with index 0 for the even pipe and index 1 for the odd pipe
  logic [3:0]  exp_op [2];
  logic [6:0]  exp_rt [2];
  logic [6:0]  exp_ra [2];
  logic [6:0]  exp_rb [2];
  logic [9:0]  exp_imm [2];
  logic        exp_wr [2];
  logic [2:0]  exp_lat [2];
  logic        exp_stall, exp_flush;
  logic [9:0]  exp_pc;

  // Index a of the in-flight write model holds age a+1
  logic        trk_wr [2][6];
  logic [6:0]  trk_dst [2][6];
  logic [2:0]  trk_lat [2][6];

  decode_issue_top dut (
    .clk (clk), .rst (rst), .is_branch (is_branch), .branch_taken (branch_taken),
    .pc_in (pc_in), .instr_in1 (instr_in1), .instr_in2 (instr_in2),
    .op_even (op_even), .rt_even (rt_even), .ra_even (ra_even), .rb_even (rb_even),
    .imm_even (imm_even), .reg_wr_even (reg_wr_even), .latency_even (latency_even),
    .op_odd (op_odd), .rt_odd (rt_odd), .ra_odd (ra_odd), .rb_odd (rb_odd),
    .imm_odd (imm_odd), .reg_wr_odd (reg_wr_odd), .latency_odd (latency_odd),
    .stall (stall), .flush (flush), .pc_out (pc_out)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  always @(posedge clk) cycle_count <= cycle_count + 1;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int rand_below(int n);
    logic [31:0] r;
    r = lcg_next();
    return int'(r[31:8] % n); // Upper bits have the longer period
  endfunction

  function automatic logic [3:0] op_code_of(logic [31:0] instr);
    return (instr[31:28] > 4'd7) ? 4'd0 : instr[31:28];
  endfunction

  function automatic logic odd_class(logic [3:0] op);
    return op inside {4'd1, 4'd5, 4'd6, 4'd7};
  endfunction

  function automatic logic [2:0] latency_of(logic [3:0] op);
    case (op)
      4'd2, 4'd3: return 3'd2;
      4'd5:       return 3'd4;
      4'd6:       return 3'd6;
      4'd4:       return 3'd7;
      4'd7:       return 3'd1;
      default:    return 3'd0;
    endcase
  endfunction

  function automatic logic writes_reg(logic [3:0] op);
    return op inside {4'd2, 4'd3, 4'd4, 4'd5, 4'd6};
  endfunction

  function automatic logic uses_ra(logic [3:0] op);
    return op inside {4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7};
  endfunction

  function automatic logic uses_rb(logic [3:0] op);
    return op inside {4'd2, 4'd4, 4'd5};
  endfunction

  // Registers stay in 0 to 7 so that hazards come often
  function automatic logic [31:0] make_instr(logic odd);
    logic [31:0] w;
    int          pick;
    pick = rand_below(5);
    w = lcg_next();
    if (odd) begin
      w[31:28] = (pick % 4 == 0) ? 4'd1 : 4'(pick % 4 + 4);
    end else begin
      case (pick)
        0:       w[31:28] = 4'd0;
        1:       w[31:28] = 4'd2;
        2:       w[31:28] = 4'd3;
        3:       w[31:28] = 4'd4;
        default: w[31:28] = 4'(8 + rand_below(8)); // Undefined code that decodes as nop
      endcase
    end
    w[27:21] = 7'(rand_below(8));
    w[20:14] = 7'(rand_below(8));
    if (uses_rb(op_code_of(w))) w[13:7] = 7'(rand_below(8));
    return w;
  endfunction

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    assert (actual === expected) else begin
      $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
      $display("Something failed");
      $fatal(1, "Stopped at the first error");
    end
  endtask

  task automatic compare_outputs(string phase);
    check_value({phase, " op_even"}, exp_op[0], op_even);
    check_value({phase, " rt_even"}, exp_rt[0], rt_even);
    check_value({phase, " ra_even"}, exp_ra[0], ra_even);
    check_value({phase, " rb_even"}, exp_rb[0], rb_even);
    check_value({phase, " imm_even"}, exp_imm[0], imm_even);
    check_value({phase, " reg_wr_even"}, exp_wr[0], reg_wr_even);
    check_value({phase, " latency_even"}, exp_lat[0], latency_even);
    check_value({phase, " op_odd"}, exp_op[1], op_odd);
    check_value({phase, " rt_odd"}, exp_rt[1], rt_odd);
    check_value({phase, " ra_odd"}, exp_ra[1], ra_odd);
    check_value({phase, " rb_odd"}, exp_rb[1], rb_odd);
    check_value({phase, " imm_odd"}, exp_imm[1], imm_odd);
    check_value({phase, " reg_wr_odd"}, exp_wr[1], reg_wr_odd);
    check_value({phase, " latency_odd"}, exp_lat[1], latency_odd);
    check_value({phase, " stall"}, exp_stall, stall);
    check_value({phase, " flush"}, exp_flush, flush);
    check_value({phase, " pc_out"}, exp_pc, pc_out);
  endtask

  task automatic clear_model();
    for (int p = 0; p < 2; p++) begin
      exp_op[p] = (p == 1) ? 4'd1 : 4'd0;
      exp_rt[p] = '0;
      exp_ra[p] = '0;
      exp_rb[p] = '0;
      exp_imm[p] = '0;
      exp_wr[p] = 1'b0;
      exp_lat[p] = '0;
      for (int a = 0; a < 6; a++) trk_wr[p][a] = 1'b0;
    end
    exp_stall = 1'b0;
    exp_flush = 1'b0;
    exp_pc = '0;
  endtask

  task automatic drive_random();
    logic [31:0] even_i;
    logic [31:0] odd_i;
    even_i = make_instr(1'b0);
    odd_i = make_instr(1'b1);
    if (rand_below(2) == 1) begin
      instr_in1 = odd_i;
      instr_in2 = even_i;
    end else begin
      instr_in1 = even_i;
      instr_in2 = odd_i;
    end
    pc_in = 10'(rand_below(1024));
    if (rand_below(12) == 0) begin
      is_branch = 1'b1;
      branch_taken = 1'b1;
    end else begin
      is_branch = 1'(rand_below(2));
      branch_taken = is_branch ? 1'b0 : 1'(rand_below(2));
    end
  endtask

  // Advances the model over one clock edge with the inputs now driven
  task automatic predict();
    logic [31:0] slot_instr [2];
    logic [3:0]  slot_op [2];
    logic [6:0]  src [4];
    logic        used [4];
    logic        hz;
    logic        kill;
    logic        at_expiry;
    slot_instr[0] = odd_class(op_code_of(instr_in1)) ? instr_in2 : instr_in1;
    slot_instr[1] = odd_class(op_code_of(instr_in1)) ? instr_in1 : instr_in2;
    for (int p = 0; p < 2; p++) begin
      slot_op[p] = op_code_of(slot_instr[p]);
      src[2*p] = slot_instr[p][20:14];
      src[2*p+1] = slot_instr[p][13:7];
      used[2*p] = uses_ra(slot_op[p]);
      used[2*p+1] = uses_rb(slot_op[p]);
    end
    hz = 1'b0;
    at_expiry = 1'b0;
    for (int s = 0; s < 4; s++) begin
      for (int q = 0; q < 2; q++) begin
        for (int a = 0; a < 6; a++) begin
          if (used[s] && trk_wr[q][a] && trk_dst[q][a] == src[s]) begin
            if (a + 1 < trk_lat[q][a]) hz = 1'b1;
            else if (a + 1 == trk_lat[q][a]) at_expiry = 1'b1;
          end
        end
      end
    end
    kill = is_branch & branch_taken;
    if (at_expiry && !hz && !kill) n_expiry++;
    if (hz && !kill) n_stall++;
    if (hz && kill) n_flush_hz++;
    for (int q = 0; q < 2; q++) begin
      for (int a = 5; a > 0; a--) begin
        trk_wr[q][a] = trk_wr[q][a-1];
        trk_dst[q][a] = trk_dst[q][a-1];
        trk_lat[q][a] = trk_lat[q][a-1];
      end
      trk_wr[q][0] = exp_wr[q];
      trk_dst[q][0] = exp_rt[q];
      trk_lat[q][0] = exp_lat[q];
      if (kill) begin
        trk_wr[q][0] = 1'b0;
        trk_wr[q][1] = 1'b0;
      end
    end
    for (int p = 0; p < 2; p++) begin
      if (kill || hz) begin
        exp_op[p] = (p == 1) ? 4'd1 : 4'd0;
        exp_rt[p] = '0;
        exp_ra[p] = '0;
        exp_rb[p] = '0;
        exp_imm[p] = '0;
        exp_wr[p] = 1'b0;
        exp_lat[p] = '0;
      end else begin
        exp_op[p] = slot_op[p];
        exp_rt[p] = slot_instr[p][27:21];
        exp_ra[p] = slot_instr[p][20:14];
        exp_rb[p] = slot_instr[p][13:7];
        exp_imm[p] = slot_instr[p][13:4];
        exp_wr[p] = writes_reg(slot_op[p]);
        exp_lat[p] = latency_of(slot_op[p]);
      end
    end
    exp_stall = hz & ~kill;
    exp_flush = kill;
    exp_pc = pc_in;
  endtask

  initial begin
    rst = 1'b1;
    is_branch = 1'b0;
    branch_taken = 1'b0;
    pc_in = '0;
    instr_in1 = '0;
    instr_in2 = '0;
    clear_model();
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #2;
      compare_outputs("reset");
      drive_random(); // Reset holds the outputs whatever the inputs do
    end
    rst = 1'b0;
    drive_random();
    predict();
    for (int i = 0; i < n_cycles; i++) begin
      @(posedge clk);
      #2; // Outputs have settled and inputs change away from the edge
      compare_outputs($sformatf("cycle %0d", i));
      drive_random();
      predict();
    end
    finished = 1'b1;
    if (n_stall == 0 || n_expiry == 0 || n_flush_hz == 0) begin
      $display("Random stimulus missed a case");
      $display("stalls %0d, issues at expiry %0d, flushes over hazard %0d",
               n_stall, n_expiry, n_flush_hz);
      $display("Something failed");
      $fatal(1, "Coverage incomplete");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

  initial begin : watchdog
    int last_count;
    last_count = -1;
    while (!finished) begin
      #(clk_period * 25);
      if (!finished && cycle_count == last_count) begin
        $display("The clock stopped advancing before the run ended");
        $display("Something failed");
        $fatal(1, "Watchdog timeout");
      end
      if (!finished && cycle_count > n_cycles + 50) begin
        $display("The run went past its cycle limit without ending");
        $display("Something failed");
        $fatal(1, "Watchdog timeout");
      end
      last_count = cycle_count;
    end
  end

endmodule

// ==== sources.f ====
common/spu_pkg.sv
common/slot_if.sv
decode/pair_decoder.sv
hazard/inflight_tracker.sv
hazard/hazard_unit.sv
design/issue_stage.sv
design/decode_issue_top.sv
test/tb_decode_issue.sv

// ==== Bender.yml ====
package:
  name: decode_issue

sources:
  - common/spu_pkg.sv
  - common/slot_if.sv
  - decode/pair_decoder.sv
  - hazard/inflight_tracker.sv
  - hazard/hazard_unit.sv
  - design/issue_stage.sv
  - design/decode_issue_top.sv
  - target: simulation
    files:
      - test/tb_decode_issue.sv
